// File: Makefile
# Verilator build and run of the microcode engine testbench
TOP := ucodeEngineTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hw/opcodeDispatch.sv
`timescale 1ns/10ps
`default_nettype none

module opcodeDispatch
	import ucodePkg::*;
#(
	parameter int UcodeAddrW = UcodeAddrWDefault
)
(
	input  wire                   clock,
	input  wire                   rstN,
	input  wire opcodeT           opcode,
	input  wire                   opcodeStrobe,
	input  wire                   flowTaken,
	output logic                  ready,
	output logic                  flowPending,
	output logic [UcodeAddrW-1:0] flowStart
);

	// Base table opcodes
	localparam opcodeT OpcNop   = 8'h00;
	localparam opcodeT OpcIncB  = 8'h04;
	localparam opcodeT OpcDecB  = 8'h05;
	localparam opcodeT OpcLdBn  = 8'h06;
	localparam opcodeT OpcAddAB = 8'h80;
	localparam opcodeT OpcSubAB = 8'h90;

	// Extended table opcodes
	localparam opcodeT CbBit7H = 8'h7C;
	localparam opcodeT CbSrlB  = 8'h38;
	localparam opcodeT CbRrB   = 8'h18;
	localparam opcodeT CbRrC   = 8'h19;
	localparam opcodeT CbRrD   = 8'h1A;
	localparam opcodeT CbRrE   = 8'h1B;
	localparam opcodeT CbRrH   = 8'h1C;
	localparam opcodeT CbRrL   = 8'h1D;
	localparam opcodeT CbRrA   = 8'h1F;

	// Flow start addresses in the micro-op ROM
	localparam logic [UcodeAddrW-1:0] AddrDefault = UcodeAddrW'(0);
	localparam logic [UcodeAddrW-1:0] AddrNop     = UcodeAddrW'(2);
	localparam logic [UcodeAddrW-1:0] AddrLdBn    = UcodeAddrW'(3);
	localparam logic [UcodeAddrW-1:0] AddrIncB    = UcodeAddrW'(6);
	localparam logic [UcodeAddrW-1:0] AddrDecB    = UcodeAddrW'(7);
	localparam logic [UcodeAddrW-1:0] AddrAddAB   = UcodeAddrW'(9);
	localparam logic [UcodeAddrW-1:0] AddrSubAB   = UcodeAddrW'(12);
	localparam logic [UcodeAddrW-1:0] AddrBit     = UcodeAddrW'(15);
	localparam logic [UcodeAddrW-1:0] AddrSrl     = UcodeAddrW'(16);
	localparam logic [UcodeAddrW-1:0] AddrRr      = UcodeAddrW'(18);

	typedef enum logic
	{
		Base,
		CbPrefix
	} dispatchStateT;

	dispatchStateT         state;
	logic                  accept;
	logic                  isPrefix;
	logic [UcodeAddrW-1:0] baseStart;
	logic [UcodeAddrW-1:0] cbStart;

	// Busy while a flow waits for the sequencer
	assign ready    = ~flowPending;
	assign accept   = opcodeStrobe & ready;
	assign isPrefix = (state == Base) && (opcode == ucodePkg::CbPrefix);

	//////////////////////////////////////////////////
	// Opcode tables
	//////////////////////////////////////////////////
	always_comb
	begin
		case (opcode)
			OpcNop:   baseStart = AddrNop;
			OpcLdBn:  baseStart = AddrLdBn;
			OpcIncB:  baseStart = AddrIncB;
			OpcDecB:  baseStart = AddrDecB;
			OpcAddAB: baseStart = AddrAddAB;
			OpcSubAB: baseStart = AddrSubAB;
			default:  baseStart = AddrDefault;
		endcase
	end

	always_comb
	begin
		case (opcode)
			CbBit7H: cbStart = AddrBit;
			CbSrlB:  cbStart = AddrSrl;
			CbRrB, CbRrC, CbRrD, CbRrE, CbRrH, CbRrL, CbRrA: cbStart = AddrRr;
			default: cbStart = AddrDefault;
		endcase
	end

	//////////////////////////////////////////////////
	// Prefix state and pending flow
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state       <= Base;
			flowPending <= 1'b0;
		end
		else
		begin
			if (flowTaken)
				flowPending <= 1'b0;
			if (accept)
			begin
				if (isPrefix)
					state <= CbPrefix;
				else
				begin
					state       <= Base;
					flowPending <= 1'b1;
				end
			end
		end
	end

	// Second byte after the prefix goes through the CB table
	always_ff @(posedge clock)
	begin
		if (accept && !isPrefix)
			flowStart <= (state == CbPrefix) ? cbStart : baseStart;
	end

endmodule

`default_nettype wire

// File: hw/ucodeEngine.sv
`timescale 1ns/10ps
`default_nettype none

module ucodeEngine
	import ucodePkg::*;
(
	input  wire         clock,
	input  wire         rstN,
	input  wire opcodeT opcode,
	input  wire         opcodeStrobe,
	output logic        ready,
	output logic        uopValid,
	output flowCtlT     uopFlow,
	output uopOpT       uopOp,
	output uopOperandT  uopOperand
);

	localparam int UcodeAddrW = UcodeAddrWDefault;

	// Dispatch to sequencer
	logic [UcodeAddrW-1:0] flowStart;
	logic                  flowPending;
	logic                  flowTaken;

	// Sequencer to ROM
	logic [UcodeAddrW-1:0] uAddr;
	logic                  uAddrValid;
	logic                  romEndOfFlow;

	opcodeDispatch #(.UcodeAddrW(UcodeAddrW)) dispatch
	(
		.clock        (clock),
		.rstN         (rstN),
		.opcode       (opcode),
		.opcodeStrobe (opcodeStrobe),
		.flowTaken    (flowTaken),
		.ready        (ready),
		.flowPending  (flowPending),
		.flowStart    (flowStart)
	);

	ucodeSequencer #(.UcodeAddrW(UcodeAddrW)) sequencer
	(
		.clock        (clock),
		.rstN         (rstN),
		.flowStart    (flowStart),
		.flowPending  (flowPending),
		.romEndOfFlow (romEndOfFlow),
		.flowTaken    (flowTaken),
		.uAddr        (uAddr),
		.uAddrValid   (uAddrValid)
	);

	ucodeRom #(.UcodeAddrW(UcodeAddrW)) rom
	(
		.clock        (clock),
		.rstN         (rstN),
		.uAddr        (uAddr),
		.uAddrValid   (uAddrValid),
		.romEndOfFlow (romEndOfFlow),
		.uopValid     (uopValid),
		.uopFlow      (uopFlow),
		.uopOp        (uopOp),
		.uopOperand   (uopOperand)
	);

endmodule

`default_nettype wire

// File: hw/ucodePkg.sv
`default_nettype none

package ucodePkg;

	// Instruction byte and micro-op field widths
	typedef logic [7:0] opcodeT;
	typedef logic [5:0] uopOpT;
	typedef logic [5:0] uopOperandT;

	// Flow control action carried in the top field of every micro-op
	typedef enum logic [2:0]
	{
		FlowOp          = 3'd0,
		FlowInc         = 3'd1,
		FlowEof         = 3'd2,
		FlowIncEof      = 3'd3,
		FlowIncEofFu    = 3'd4,
		FlowEofFu       = 3'd5,
		FlowUpdateFlags = 3'd6
	} flowCtlT;

	// Extended table prefix byte
	localparam opcodeT CbPrefix = 8'hCB;

	localparam int UcodeAddrWDefault = 6;

	//////////////////////////////////////////////////
	// Operation field codes
	//////////////////////////////////////////////////
	localparam uopOpT OpNop     = 6'd0;
	localparam uopOpT OpSma     = 6'd1;
	localparam uopOpT OpSrm     = 6'd2;
	localparam uopOpT OpInc16   = 6'd3;
	localparam uopOpT OpDec16   = 6'd4;
	localparam uopOpT OpSx16r   = 6'd5;
	localparam uopOpT OpSrx16   = 6'd6;
	localparam uopOpT OpAddx16u = 6'd7;
	localparam uopOpT OpSubx16  = 6'd8;
	localparam uopOpT OpZ801bop = 6'd9;
	localparam uopOpT OpBit     = 6'd10;
	localparam uopOpT OpShr     = 6'd11;
	localparam uopOpT OpRrot    = 6'd12;

	// Operand field codes
	localparam uopOperandT RegNull = 6'd0;
	localparam uopOperandT RegA    = 6'd1;
	localparam uopOperandT RegB    = 6'd2;
	localparam uopOperandT RegPc   = 6'd3;

	// True for every flow control value that closes a flow
	function automatic logic isEndOfFlow(input flowCtlT flow);
		logic eof;
		case (flow)
			FlowEof, FlowIncEof, FlowIncEofFu, FlowEofFu: eof = 1'b1;
			default: eof = 1'b0;
		endcase
		return eof;
	endfunction

endpackage

`default_nettype wire

// File: hw/ucodeRom.sv
`timescale 1ns/10ps
`default_nettype none

module ucodeRom
	import ucodePkg::*;
#(
	parameter int UcodeAddrW = UcodeAddrWDefault
)
(
	input  wire                  clock,
	input  wire                  rstN,
	input  wire [UcodeAddrW-1:0] uAddr,
	input  wire                  uAddrValid,
	output logic                 romEndOfFlow,
	output logic                 uopValid,
	output flowCtlT              uopFlow,
	output uopOpT                uopOp,
	output uopOperandT           uopOperand
);

	// Flow, operation, operand
	typedef logic [14:0] uopWordT;

	function automatic uopWordT uop(input flowCtlT flow, input uopOpT op, input uopOperandT rd);
		return {flow, op, rd};
	endfunction

	uopWordT romWord;
	flowCtlT romFlow;

	//////////////////////////////////////////////////
	// Flow table
	//////////////////////////////////////////////////
	always_comb
	begin
		case (int'(uAddr))
			// Default one byte ALU op
			0:  romWord = uop(FlowUpdateFlags, OpZ801bop, RegA);
			1:  romWord = uop(FlowIncEof, OpNop, RegNull);
			// NOP
			2:  romWord = uop(FlowIncEof, OpNop, RegNull);
			// LD B,n
			3:  romWord = uop(FlowInc, OpSma, RegPc);
			4:  romWord = uop(FlowInc, OpNop, RegNull);
			5:  romWord = uop(FlowEof, OpSrm, RegB);
			// INC B
			6:  romWord = uop(FlowIncEofFu, OpInc16, RegB);
			// DEC B
			7:  romWord = uop(FlowUpdateFlags, OpDec16, RegB);
			8:  romWord = uop(FlowIncEof, OpNop, RegNull);
			// ADD A,B
			9:  romWord = uop(FlowOp, OpSx16r, RegA);
			10: romWord = uop(FlowUpdateFlags, OpAddx16u, RegB);
			11: romWord = uop(FlowIncEof, OpSrx16, RegA);
			// SUB A,B
			12: romWord = uop(FlowOp, OpSx16r, RegA);
			13: romWord = uop(FlowUpdateFlags, OpSubx16, RegB);
			14: romWord = uop(FlowIncEof, OpSrx16, RegA);
			// CB BIT 7,H
			15: romWord = uop(FlowEofFu, OpBit, RegNull);
			// CB SRL B
			16: romWord = uop(FlowUpdateFlags, OpShr, RegNull);
			17: romWord = uop(FlowEof, OpNop, RegNull);
			// CB RR r
			18: romWord = uop(FlowUpdateFlags, OpRrot, RegNull);
			19: romWord = uop(FlowEof, OpNop, RegNull);
			default: romWord = uop(FlowOp, OpNop, RegNull);
		endcase
	end

	// Lets the sequencer stop on the current word
	assign romFlow      = flowCtlT'(romWord[14:12]);
	assign romEndOfFlow = isEndOfFlow(romFlow);

	//////////////////////////////////////////////////
	// Registered micro-op output
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (!rstN)
			uopValid <= 1'b0;
		else
			uopValid <= uAddrValid;
	end

	always_ff @(posedge clock)
	begin
		uopFlow    <= romFlow;
		uopOp      <= romWord[11:6];
		uopOperand <= romWord[5:0];
	end

endmodule

`default_nettype wire

// File: hw/ucodeSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module ucodeSequencer
	import ucodePkg::*;
#(
	parameter int UcodeAddrW = UcodeAddrWDefault
)
(
	input  wire                   clock,
	input  wire                   rstN,
	input  wire [UcodeAddrW-1:0]  flowStart,
	input  wire                   flowPending,
	input  wire                   romEndOfFlow,
	output logic                  flowTaken,
	output logic [UcodeAddrW-1:0] uAddr,
	output logic                  uAddrValid
);

	typedef enum logic
	{
		Idle,
		Run
	} seqStateT;

	seqStateT state;
	logic     atEnd;

	// End of flow only means something while a flow runs
	assign atEnd      = (state == Run) && romEndOfFlow;
	assign uAddrValid = (state == Run);

	// Chain the pending flow straight after the end word
	assign flowTaken = flowPending && ((state == Idle) || atEnd);

	//////////////////////////////////////////////////
	// Micro-program counter
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (!rstN)
			state <= Idle;
		else if (flowTaken)
			state <= Run;
		else if (atEnd)
			state <= Idle;
	end

	always_ff @(posedge clock)
	begin
		if (flowTaken)
			uAddr <= flowStart;
		else if ((state == Run) && !romEndOfFlow)
			uAddr <= uAddr + UcodeAddrW'(1);
	end

endmodule

`default_nettype wire

// File: verif/ucodeEngineTb.sv
`timescale 1ns/10ps
`default_nettype none

module ucodeEngineTb
	import ucodePkg::*;
();

	localparam int WaitLimit   = 50;
	localparam int RandomBytes = 40;

	logic       clock;
	logic       rstN;
	opcodeT     opcode;
	logic       opcodeStrobe;
	logic       ready;
	logic       uopValid;
	flowCtlT    uopFlow;
	uopOpT      uopOp;
	uopOperandT uopOperand;

	int          valueErrors   = 0;
	int          timeoutErrors = 0;
	int          seed          = 32'h257e;
	bit          cbMode        = 1'b0;
	logic [14:0] expQ [$];

	ucodeEngine uut
	(
		.clock        (clock),
		.rstN         (rstN),
		.opcode       (opcode),
		.opcodeStrobe (opcodeStrobe),
		.ready        (ready),
		.uopValid     (uopValid),
		.uopFlow      (uopFlow),
		.uopOp        (uopOp),
		.uopOperand   (uopOperand)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Reference flow model
	//////////////////////////////////////////////////
	function automatic logic [14:0] refRow(input int addr);
		case (addr)
			0:  return {FlowUpdateFlags, OpZ801bop, RegA};
			1:  return {FlowIncEof, OpNop, RegNull};
			2:  return {FlowIncEof, OpNop, RegNull};
			3:  return {FlowInc, OpSma, RegPc};
			4:  return {FlowInc, OpNop, RegNull};
			5:  return {FlowEof, OpSrm, RegB};
			6:  return {FlowIncEofFu, OpInc16, RegB};
			7:  return {FlowUpdateFlags, OpDec16, RegB};
			8:  return {FlowIncEof, OpNop, RegNull};
			9:  return {FlowOp, OpSx16r, RegA};
			10: return {FlowUpdateFlags, OpAddx16u, RegB};
			11: return {FlowIncEof, OpSrx16, RegA};
			12: return {FlowOp, OpSx16r, RegA};
			13: return {FlowUpdateFlags, OpSubx16, RegB};
			14: return {FlowIncEof, OpSrx16, RegA};
			15: return {FlowEofFu, OpBit, RegNull};
			16: return {FlowUpdateFlags, OpShr, RegNull};
			17: return {FlowEof, OpNop, RegNull};
			18: return {FlowUpdateFlags, OpRrot, RegNull};
			19: return {FlowEof, OpNop, RegNull};
			default: return {FlowOp, OpNop, RegNull};
		endcase
	endfunction

	function automatic int flowLength(input int start);
		case (start)
			0, 7, 16, 18: return 2;
			3, 9, 12:     return 3;
			default:      return 1;
		endcase
	endfunction

	function automatic int baseStartOf(input opcodeT op);
		case (op)
			8'h00:   return 2;
			8'h06:   return 3;
			8'h04:   return 6;
			8'h05:   return 7;
			8'h80:   return 9;
			8'h90:   return 12;
			default: return 0;
		endcase
	endfunction

	function automatic int cbStartOf(input opcodeT op);
		case (op)
			8'h7C: return 15;
			8'h38: return 16;
			8'h18, 8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1F: return 18;
			default: return 0;
		endcase
	endfunction

	// Prefix state of the model follows every byte sent
	task automatic modelByte(input opcodeT op);
		int start;
		int i;
		if (!cbMode && op == CbPrefix)
			cbMode = 1'b1;
		else
		begin
			start  = cbMode ? cbStartOf(op) : baseStartOf(op);
			cbMode = 1'b0;
			for (i = 0; i < flowLength(start); i++)
				expQ.push_back(refRow(start + i));
		end
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic checkFlow(input flowCtlT got, input flowCtlT exp, input string what);
		if (got !== exp)
		begin
			valueErrors++;
			$display("FAIL %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic checkOp(input uopOpT got, input uopOpT exp, input string what);
		if (got !== exp)
		begin
			valueErrors++;
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkOperand(input uopOperandT got, input uopOperandT exp, input string what);
		if (got !== exp)
		begin
			valueErrors++;
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			valueErrors++;
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeoutErrors++;
		$display("Timeout at %0t while waiting for %s", $time, what);
	endtask

	//////////////////////////////////////////////////
	// Drive and expect
	//////////////////////////////////////////////////
	task automatic sendOpcode(input opcodeT op);
		int waitN;
		waitN = 0;
		@(posedge clock);
		#2;
		while (!ready && waitN < WaitLimit)
		begin
			@(posedge clock);
			#2;
			waitN++;
		end
		if (!ready)
			reportTimeout("ready before an opcode");
		else
		begin
			opcode       = op;
			opcodeStrobe = 1'b1;
			@(posedge clock);
			#2;
			opcodeStrobe = 1'b0;
		end
	endtask

	// Outputs sampled on the falling edge, half a cycle after they change
	task automatic expectFlow(input int expLatency, input bit allowGaps);
		int          waitN;
		bit          lost;
		logic [14:0] row;
		waitN = 0;
		lost  = 1'b0;
		@(negedge clock);
		while (!uopValid && waitN < WaitLimit)
		begin
			@(negedge clock);
			waitN++;
		end
		if (!uopValid)
		begin
			reportTimeout("the first micro-op");
			expQ.delete();
			lost = 1'b1;
		end
		else if (expLatency >= 0 && waitN != expLatency)
		begin
			valueErrors++;
			$display("FAIL %0t: first micro-op after %0d cycles, expected %0d",
				$time, waitN, expLatency);
		end
		while (expQ.size() > 0)
		begin
			row = expQ.pop_front();
			checkBit(uopValid, 1'b1, "uopValid inside a flow");
			checkFlow(uopFlow, flowCtlT'(row[14:12]), "uopFlow");
			checkOp(uopOp, row[11:6], "uopOp");
			checkOperand(uopOperand, row[5:0], "uopOperand");
			if (expQ.size() == 0)
				checkBit(isEndOfFlow(uopFlow), 1'b1, "end of flow class of last micro-op");
			else
			begin
				@(negedge clock);
				waitN = 0;
				while (allowGaps && !uopValid && waitN < WaitLimit)
				begin
					@(negedge clock);
					waitN++;
				end
				if (!uopValid && allowGaps)
				begin
					reportTimeout("the next micro-op");
					expQ.delete();
					lost = 1'b1;
				end
			end
		end
		if (!lost)
		begin
			@(negedge clock);
			checkBit(uopValid, 1'b0, "uopValid after the last flow");
		end
	endtask

	task automatic runSingle(input opcodeT op);
		modelByte(op);
		sendOpcode(op);
		expectFlow(2, 1'b0);
	endtask

	task automatic runCb(input opcodeT op);
		modelByte(CbPrefix);
		sendOpcode(CbPrefix);
		runSingle(op);
	endtask

	task automatic runPair(input opcodeT first, input opcodeT second);
		modelByte(first);
		modelByte(second);
		fork
			begin
				sendOpcode(first);
				sendOpcode(second);
			end
			expectFlow(-1, 1'b0);
		join
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic testReset();
		checkBit(uopValid, 1'b0, "uopValid after reset");
		checkBit(ready, 1'b1, "ready after reset");
	endtask

	task automatic testBaseOpcodes();
		opcodeT ops [6];
		ops = '{8'h00, 8'h06, 8'h04, 8'h05, 8'h80, 8'h90};
		foreach (ops[i])
			runSingle(ops[i]);
	endtask

	task automatic testCbFlows();
		opcodeT cbOps [9];
		cbOps = '{8'h38, 8'h18, 8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1F, 8'h00};
		// Prefix byte on its own makes no flow
		modelByte(CbPrefix);
		sendOpcode(CbPrefix);
		checkBit(ready, 1'b1, "ready after prefix");
		repeat (3)
		begin
			@(negedge clock);
			checkBit(uopValid, 1'b0, "uopValid after prefix");
		end
		runSingle(8'h7C);
		foreach (cbOps[i])
			runCb(cbOps[i]);
	endtask

	task automatic testDefaultFlow();
		runSingle(8'h3C);
	endtask

	task automatic testBackToBack();
		runPair(8'h80, 8'h90);
		runPair(8'h06, 8'h05);
	endtask

	task automatic testRandomStream();
		opcodeT pool [14];
		opcodeT stream [$];
		int     idx;
		int     n;
		pool = '{8'h00, 8'h06, 8'h04, 8'h05, 8'h80, 8'h90, CbPrefix,
			8'h3C, 8'h7C, 8'h38, 8'h18, 8'h1D, 8'h1F, 8'hFF};
		for (n = 0; n < RandomBytes; n++)
		begin
			idx = $unsigned($random(seed)) % 14;
			stream.push_back(pool[idx]);
			modelByte(pool[idx]);
		end
		// Close a trailing prefix
		if (cbMode)
		begin
			stream.push_back(8'h00);
			modelByte(8'h00);
		end
		fork
			begin
				foreach (stream[i])
					sendOpcode(stream[i]);
			end
			expectFlow(-1, 1'b1);
		join
	endtask

	initial
	begin
		rstN         = 1'b0;
		opcode       = 8'h00;
		opcodeStrobe = 1'b0;
		repeat (2) @(posedge clock);
		#2;
		rstN = 1'b1;
		testReset();
		testBaseOpcodes();
		testCbFlows();
		testDefaultFlow();
		testBackToBack();
		testRandomStream();
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			valueErrors, timeoutErrors, uut.assertChecks.failCount);
		if (valueErrors == 0 && timeoutErrors == 0 && uut.assertChecks.failCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/ucodeEngine_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module ucodeEngineAssertions
	import ucodePkg::*;
(
	input wire          clock,
	input wire          rstN,
	input wire          opcodeStrobe,
	input wire          ready,
	input wire          uopValid,
	input wire flowCtlT uopFlow
);

	int failCount = 0;

	// Outside must hold opcodes while a flow is pending
	strobeWhileBusy: assert property (@(posedge clock) disable iff (!rstN)
		opcodeStrobe |-> ready)
	else
	begin
		failCount++;
		$error("opcode strobe while ready is low");
	end

	legalFlowField: assert property (@(posedge clock) disable iff (!rstN)
		uopValid |-> (uopFlow inside {FlowOp, FlowInc, FlowEof, FlowIncEof,
			FlowIncEofFu, FlowEofFu, FlowUpdateFlags}))
	else
	begin
		failCount++;
		$error("illegal flow control value on a valid micro-op");
	end

	// First cycle out of reset
	quietAfterReset: assert property (@(posedge clock) $rose(rstN) |-> !uopValid)
	else
	begin
		failCount++;
		$error("uopValid high right after reset");
	end

endmodule

bind ucodeEngine ucodeEngineAssertions assertChecks
(
	.clock        (clock),
	.rstN         (rstN),
	.opcodeStrobe (opcodeStrobe),
	.ready        (ready),
	.uopValid     (uopValid),
	.uopFlow      (uopFlow)
);

`default_nettype wire

// File: verilog.f
hw/ucodePkg.sv
hw/opcodeDispatch.sv
hw/ucodeSequencer.sv
hw/ucodeRom.sv
hw/ucodeEngine.sv
verif/ucodeEngine_assertions.sv
verif/ucodeEngineTb.sv
